// ==== logic/game_video_pkg.sv ====
package game_video_pkg;

    typedef logic [8:0] hpos_t;    // Pixel within a line
    typedef logic [8:0] vpos_t;    // Line within a frame
    typedef logic [3:0] pixel_t;   // Colour index of one pixel

    typedef struct packed {
        pixel_t red;
        pixel_t green;
        pixel_t blue;
    } rgb_t;

    // Blanking flags are high in the visible area, sync flags during the pulse
    typedef struct packed {
        logic lhbl;
        logic lvbl;
        logic hs;
        logic vs;
    } video_sync_t;

endpackage

// ==== logic/game_mem_pkg.sv ====
package game_mem_pkg;

    typedef logic [21:0] rom_addr_t;   // SDRAM word address
    typedef logic [31:0] rom_word_t;   // One ROM word, eight 4-bit pixels for tiles

    // Read request, shared by every client of the ROM port
    typedef struct packed {
        rom_addr_t addr;
    } rom_req_t;

endpackage

// ==== logic/game_timer.sv ====
module game_timer
    import game_video_pkg::*;
#(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int HS_START = 296,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 264,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 240,
    parameter int VS_LEN   = 8,
    parameter int CEN_DIV  = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        game_rst,
    output logic        cen_pix,
    output hpos_t       h,
    output vpos_t       v,
    output video_sync_t sync
);

    logic [1:0] cen_cnt;
    logic       h_last;

    assign h_last = h == hpos_t'(H_TOTAL - 1);

    // Pixel enable keeps running through game reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt <= 2'd0;
            cen_pix <= 1'b0;
        end else begin
            cen_cnt <= (cen_cnt == 2'(CEN_DIV - 1)) ? 2'd0 : cen_cnt + 2'd1;
            cen_pix <= cen_cnt == 2'(CEN_DIV - 1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h <= '0;
            v <= '0;
        end else if (game_rst) begin
            h <= '0;
            v <= '0;
        end else if (cen_pix) begin
            if (h_last) begin
                h <= '0;
                v <= (v == vpos_t'(V_TOTAL - 1)) ? '0 : v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // Decoded one clk behind h and v, settled well before the next cen_pix
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync <= '0;
        end else if (game_rst) begin
            sync <= '0;    // Blanked, no pulses
        end else begin
            sync.lhbl <= h < hpos_t'(H_ACTIVE);
            sync.lvbl <= v < vpos_t'(V_ACTIVE);
            sync.hs   <= h >= hpos_t'(HS_START) && h < hpos_t'(HS_START + HS_LEN);
            sync.vs   <= v >= vpos_t'(VS_START) && v < vpos_t'(VS_START + VS_LEN);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        h < hpos_t'(H_TOTAL) && v < vpos_t'(V_TOTAL));

endmodule

// ==== logic/game_char_fetch.sv ====
module game_char_fetch
    import game_video_pkg::*;
    import game_mem_pkg::*;
#(
    parameter int H_ACTIVE = 256
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        game_rst,
    input  logic        cen_pix,
    input  hpos_t       h,
    input  vpos_t       v,
    input  video_sync_t sync,
    input  logic        char_en,
    input  logic [7:0]  char_base,
    output rom_req_t    char_req,
    output logic        char_valid,
    input  logic        char_ready,
    input  rom_word_t   char_data,
    input  logic        char_data_valid,
    output logic        underrun,
    output rgb_t        rgb,
    output video_sync_t sync_out
);

    logic       cen_d;       // First clk with the new h
    logic       tile_start;
    logic       wait_data;   // Granted, word not back yet
    logic       have;        // Prefetched word on hand
    logic       drop;        // Word in flight belongs to a tile already shown
    logic       pend;
    logic       fresh;
    logic       last_tile;
    logic [4:0] col_nxt;
    vpos_t      v_fetch;
    rom_word_t  nxt_word;
    rom_word_t  cur_word;    // Low nibble is the pixel on screen
    pixel_t     pix;

    assign tile_start = cen_d && h[2:0] == 3'd0 && h < hpos_t'(H_ACTIVE);
    assign fresh      = char_data_valid && !drop;
    assign pend       = char_valid || (wait_data && !char_data_valid);
    assign last_tile  = h >= hpos_t'(H_ACTIVE - 8);
    // Last tile of a line prefetches column 0 of the following line
    assign col_nxt    = last_tile ? 5'd0 : h[7:3] + 5'd1;
    assign v_fetch    = !last_tile ? v : (sync.lvbl ? v + 1'b1 : '0);
    assign pix        = cur_word[3:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_d      <= 1'b0;
            char_valid <= 1'b0;
            wait_data  <= 1'b0;
            have       <= 1'b0;
            drop       <= 1'b0;
            underrun   <= 1'b0;
        end else if (game_rst) begin
            cen_d      <= 1'b0;
            char_valid <= 1'b0;
            wait_data  <= 1'b0;
            have       <= 1'b0;
            drop       <= 1'b0;
            underrun   <= 1'b0;
        end else begin
            cen_d    <= cen_pix;
            underrun <= 1'b0;
            if (char_valid && char_ready) begin
                char_valid <= 1'b0;
                wait_data  <= 1'b1;
            end
            if (char_data_valid) begin
                wait_data <= 1'b0;
                drop      <= 1'b0;
                if (!drop) begin
                    have <= 1'b1;
                end
            end
            if (tile_start) begin
                have <= 1'b0;    // Consumed by this tile
                if (!have && !fresh && pend) begin
                    underrun <= 1'b1;
                    drop     <= 1'b1;
                end
                if (!pend) begin
                    char_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_start && !pend) begin
            char_req.addr <= {char_base, v_fetch, col_nxt};
        end
        if (fresh) begin
            nxt_word <= char_data;
        end
        if (tile_start) begin
            cur_word <= have ? nxt_word : (fresh ? char_data : '0);
        end else if (cen_d) begin
            cur_word <= cur_word >> 4;
        end
    end

    // Colour leaves together with the sync of the same pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb      <= '0;
            sync_out <= '0;
        end else begin
            sync_out <= sync;
            if (char_en && sync.lhbl && sync.lvbl) begin
                rgb <= '{red: pix, green: pix, blue: pix};
            end else begin
                rgb <= '0;
            end
        end
    end

    // Only one tile word in flight between grant and strobe
    assert property (@(posedge clk) disable iff (!arst_n || game_rst)
        char_valid && char_ready |=> !char_valid until char_data_valid);

endmodule

// ==== logic/game_rom_arb.sv ====
module game_rom_arb
    import game_mem_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      downloading,
    input  rom_req_t  char_req,
    input  logic      char_valid,
    output logic      char_ready,
    output rom_word_t char_data,
    output logic      char_data_valid,
    input  rom_req_t  host_req,
    input  logic      host_valid,
    output logic      host_ready,
    output rom_word_t host_data,
    output logic      host_data_valid,
    output logic      sdram_req,
    output rom_addr_t sdram_addr,
    input  logic      sdram_ack,
    input  rom_word_t data_read,
    input  logic      data_rdy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } arb_state_t;

    arb_state_t state;
    logic       owner_host;   // Owner of the transfer in flight
    logic       grant_ok;

    assign grant_ok   = state == ST_IDLE && !downloading;
    assign char_ready = grant_ok;
    assign host_ready = grant_ok && !char_valid;   // Raster cannot wait
    assign sdram_req  = state == ST_REQ;           // Held until ack

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= ST_IDLE;
            owner_host      <= 1'b0;
            char_data_valid <= 1'b0;
            host_data_valid <= 1'b0;
        end else begin
            char_data_valid <= 1'b0;
            host_data_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (char_ready && char_valid) begin
                        owner_host <= 1'b0;
                        state      <= ST_REQ;
                    end else if (host_ready && host_valid) begin
                        owner_host <= 1'b1;
                        state      <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        state           <= ST_IDLE;
                        char_data_valid <= !owner_host;
                        host_data_valid <= owner_host;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            sdram_addr <= char_valid ? char_req.addr : host_req.addr;   // Frozen once granted
        end
        if (state == ST_WAIT && data_rdy) begin
            if (owner_host) begin
                host_data <= data_read;
            end else begin
                char_data <= data_read;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr));

endmodule

// ==== logic/game_cfg_regs.sv ====
module game_cfg_regs (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       downloading,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_wdata,
    output logic [7:0] cfg_rdata,
    input  logic       underrun,
    output logic       char_en,
    output logic [7:0] char_base,
    output logic       game_rst,
    output logic       rom_ready
);

    logic [1:0] rst_sr;   // Keeps the game in reset two clk past the download
    logic       underrun_st;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sr    <= 2'b11;
            rom_ready <= 1'b0;
        end else begin
            rst_sr    <= {rst_sr[0], downloading};
            rom_ready <= !downloading;
        end
    end

    assign game_rst = downloading || rst_sr[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            char_en     <= 1'b0;
            char_base   <= 8'd0;
            underrun_st <= 1'b0;
        end else begin
            if (cfg_we) begin
                case (cfg_addr)
                    2'd0: char_en <= cfg_wdata[0];
                    2'd1: char_base <= cfg_wdata;
                    2'd2: underrun_st <= 1'b0;   // Any value clears
                    default: ;
                endcase
            end
            if (underrun) begin
                underrun_st <= 1'b1;   // A new event beats the clear
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            2'd0: cfg_rdata = {7'd0, char_en};
            2'd1: cfg_rdata = char_base;
            2'd2: cfg_rdata = {6'd0, rom_ready, underrun_st};
            default: cfg_rdata = 8'd0;
        endcase
    end

endmodule

// ==== logic/game_top.sv ====
module game_top
    import game_video_pkg::*;
    import game_mem_pkg::*;
#(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int HS_START = 296,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 264,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 240,
    parameter int VS_LEN   = 8,
    parameter int CEN_DIV  = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    // Host ROM reads
    input  rom_req_t    host_req,
    input  logic        host_valid,
    output logic        host_ready,
    output rom_word_t   host_data,
    output logic        host_data_valid,
    // SDRAM
    output logic        sdram_req,
    output rom_addr_t   sdram_addr,
    input  logic        sdram_ack,
    input  rom_word_t   data_read,
    input  logic        data_rdy,
    // Configuration
    input  logic        cfg_we,
    input  logic [1:0]  cfg_addr,
    input  logic [7:0]  cfg_wdata,
    output logic [7:0]  cfg_rdata,
    output logic        rom_ready,
    // Video
    output rgb_t        rgb,
    output video_sync_t sync
);

    logic        game_rst;
    logic        cen_pix;
    hpos_t       h;
    vpos_t       v;
    video_sync_t raw_sync;   // Timer sync, one stage ahead of the colour
    rom_req_t    char_req;
    logic        char_valid;
    logic        char_ready;
    rom_word_t   char_data;
    logic        char_data_valid;
    logic        underrun;
    logic        char_en;
    logic [7:0]  char_base;

    game_timer #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   ),
        .CEN_DIV  ( CEN_DIV  )
    ) u_timer (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .game_rst ( game_rst ),
        .cen_pix  ( cen_pix  ),
        .h        ( h        ),
        .v        ( v        ),
        .sync     ( raw_sync )
    );

    game_char_fetch #(
        .H_ACTIVE ( H_ACTIVE )
    ) u_char (
        .clk             ( clk             ),
        .arst_n          ( arst_n          ),
        .game_rst        ( game_rst        ),
        .cen_pix         ( cen_pix         ),
        .h               ( h               ),
        .v               ( v               ),
        .sync            ( raw_sync        ),
        .char_en         ( char_en         ),
        .char_base       ( char_base       ),
        .char_req        ( char_req        ),
        .char_valid      ( char_valid      ),
        .char_ready      ( char_ready      ),
        .char_data       ( char_data       ),
        .char_data_valid ( char_data_valid ),
        .underrun        ( underrun        ),
        .rgb             ( rgb             ),
        .sync_out        ( sync            )
    );

    game_rom_arb u_arb (
        .clk             ( clk             ),
        .arst_n          ( arst_n          ),
        .downloading     ( downloading     ),
        .char_req        ( char_req        ),
        .char_valid      ( char_valid      ),
        .char_ready      ( char_ready      ),
        .char_data       ( char_data       ),
        .char_data_valid ( char_data_valid ),
        .host_req        ( host_req        ),
        .host_valid      ( host_valid      ),
        .host_ready      ( host_ready      ),
        .host_data       ( host_data       ),
        .host_data_valid ( host_data_valid ),
        .sdram_req       ( sdram_req       ),
        .sdram_addr      ( sdram_addr      ),
        .sdram_ack       ( sdram_ack       ),
        .data_read       ( data_read       ),
        .data_rdy        ( data_rdy        )
    );

    game_cfg_regs u_cfg (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .cfg_we      ( cfg_we      ),
        .cfg_addr    ( cfg_addr    ),
        .cfg_wdata   ( cfg_wdata   ),
        .cfg_rdata   ( cfg_rdata   ),
        .underrun    ( underrun    ),
        .char_en     ( char_en     ),
        .char_base   ( char_base   ),
        .game_rst    ( game_rst    ),
        .rom_ready   ( rom_ready   )
    );

endmodule

// ==== tb/game_tb.sv ====
module game_tb
    import game_video_pkg::*;
    import game_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int HS_START = 52;
    localparam int HS_LEN   = 4;
    localparam int V_TOTAL  = 20;
    localparam int V_ACTIVE = 16;
    localparam int VS_START = 17;
    localparam int VS_LEN   = 2;
    localparam int CEN_DIV  = 4;

    localparam int LINE_CLK   = H_TOTAL * CEN_DIV;
    localparam int FRAME_CLK  = V_TOTAL * LINE_CLK;
    localparam int EDGE_LIMIT = 2 * FRAME_CLK;   // Longest wait for any sync edge
    localparam int XFER_LIMIT = 200;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    rom_req_t    host_req;
    logic        host_valid;
    logic        host_ready;
    rom_word_t   host_data;
    logic        host_data_valid;
    logic        sdram_req;
    rom_addr_t   sdram_addr;
    logic        sdram_ack;
    rom_word_t   data_read;
    logic        data_rdy;
    logic        cfg_we;
    logic [1:0]  cfg_addr;
    logic [7:0]  cfg_wdata;
    logic [7:0]  cfg_rdata;
    logic        rom_ready;
    rgb_t        rgb;
    video_sync_t sync;

    int errors;
    int timeouts;
    bit aborted;
    int ack_delay;   // Cycles from seeing sdram_req to ack

    game_top #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   ),
        .CEN_DIV  ( CEN_DIV  )
    ) i_dut (
        .clk             ( clk             ),
        .arst_n          ( arst_n          ),
        .downloading     ( downloading     ),
        .host_req        ( host_req        ),
        .host_valid      ( host_valid      ),
        .host_ready      ( host_ready      ),
        .host_data       ( host_data       ),
        .host_data_valid ( host_data_valid ),
        .sdram_req       ( sdram_req       ),
        .sdram_addr      ( sdram_addr      ),
        .sdram_ack       ( sdram_ack       ),
        .data_read       ( data_read       ),
        .data_rdy        ( data_rdy        ),
        .cfg_we          ( cfg_we          ),
        .cfg_addr        ( cfg_addr        ),
        .cfg_wdata       ( cfg_wdata       ),
        .cfg_rdata       ( cfg_rdata       ),
        .rom_ready       ( rom_ready       ),
        .rgb             ( rgb             ),
        .sync            ( sync            )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Model ROM word depends on every address bit
    function automatic rom_word_t rom_word(input rom_addr_t a);
        return (32'(a) * 32'h9e37_79b1) ^ {10'h2a5, a};
    endfunction

    function automatic pixel_t expected_pixel(input logic [7:0] base, input int x, input int y);
        rom_addr_t a;
        rom_word_t w;
        a = {base, 9'(y), 5'(x / 8)};
        w = rom_word(a);
        return pixel_t'(w >> (4 * (x % 8)));   // Low nibble first
    endfunction

    function automatic bit sync_bit(input int sel);
        case (sel)
            0: return sync.lhbl;
            1: return sync.lvbl;
            2: return sync.hs;
            default: return sync.vs;
        endcase
    endfunction

    // SDRAM model serves one transfer at a time
    initial begin
        int        ack_cnt;
        int        rdy_cnt;
        rom_addr_t req_addr;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        ack_cnt   = 0;
        rdy_cnt   = 0;
        req_addr  = '0;
        forever begin
            @(posedge clk);
            #10;
            sdram_ack = 1'b0;
            data_rdy  = 1'b0;
            if (ack_cnt > 0) begin
                ack_cnt--;
                if (ack_cnt == 0) begin
                    sdram_ack = 1'b1;
                    rdy_cnt   = 3;
                end
            end else if (rdy_cnt > 0) begin
                rdy_cnt--;
                if (rdy_cnt == 0) begin
                    data_rdy  = 1'b1;
                    data_read = rom_word(req_addr);
                end
            end else if (sdram_req) begin
                req_addr = sdram_addr;
                ack_cnt  = ack_delay;
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, want);
        end
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("Timeout: no %s within the allowed number of cycles", what);
    endtask

    task automatic cfg_write(input logic [1:0] a, input logic [7:0] d);
        cfg_addr  = a;
        cfg_wdata = d;
        cfg_we    = 1'b1;
        step();
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input logic [1:0] a, output logic [7:0] d);
        cfg_addr = a;
        #1;
        d = cfg_rdata;
    endtask

    // Also checks that blanked pixels stay black
    task automatic wait_rise(input int sel, input string what);
        int n;
        bit prev;
        n    = 0;
        prev = sync_bit(sel);
        forever begin
            step();
            if (!(sync.lhbl && sync.lvbl)) begin
                check_equal("rgb in blanking", rgb, '0);
            end
            if (!prev && sync_bit(sel)) begin
                return;
            end
            prev = sync_bit(sel);
            n++;
            if (n > EDGE_LIMIT) begin
                timed_out(what);
                return;
            end
        end
    endtask

    task automatic measure_sync(input int sel, output int high_len, output int period);
        bit prev;
        bit cur;
        high_len = 0;
        period   = 0;
        wait_rise(sel, "rising sync edge");
        if (aborted) return;
        high_len = 1;
        prev     = 1'b1;
        forever begin
            step();
            period++;
            cur = sync_bit(sel);
            if (!prev && cur) begin
                return;
            end
            if (cur) high_len++;
            prev = cur;
            if (period > EDGE_LIMIT) begin
                timed_out("second rising sync edge");
                return;
            end
        end
    endtask

    task automatic check_frame(input logic [7:0] base, input bit en);
        pixel_t p;
        rgb_t   want;
        wait_rise(1, "frame start");
        if (aborted) return;
        for (int y = 0; y < V_ACTIVE; y++) begin
            if (y > 0) begin
                wait_rise(0, "line start");
                if (aborted) return;
            end
            for (int x = 0; x < H_ACTIVE; x++) begin
                p    = en ? expected_pixel(base, x, y) : '0;
                want = '{red: p, green: p, blue: p};
                check_equal($sformatf("rgb at %0d,%0d", x, y), rgb, want);
                repeat (CEN_DIV) step();   // One sample per pixel
            end
        end
    endtask

    task automatic host_read(input rom_addr_t a);
        int n;
        host_req.addr = a;
        host_valid    = 1'b1;
        n             = 0;
        while (!host_ready) begin
            step();
            n++;
            if (n > XFER_LIMIT) begin
                host_valid = 1'b0;
                timed_out("host_ready");
                return;
            end
        end
        step();   // Grant edge
        host_valid = 1'b0;
        n          = 0;
        while (!host_data_valid) begin
            step();
            n++;
            if (n > XFER_LIMIT) begin
                timed_out("host_data_valid");
                return;
            end
        end
        check_equal("host_data", host_data, rom_word(a));
    endtask

    task automatic download_gating();
        logic [7:0] st;
        host_req.addr = 22'h01234;
        host_valid    = 1'b1;   // Must not be granted yet
        for (int i = 0; i < 16; i++) begin
            step();
            cfg_read(2'd2, st);
            check_equal("rom_ready status bit", st[1], 1'b0);
            check_equal("rom_ready", rom_ready, 1'b0);
            check_equal("sdram_req", sdram_req, 1'b0);
            check_equal("host_ready", host_ready, 1'b0);
            check_equal("sync", sync, '0);
            check_equal("rgb", rgb, '0);
        end
        host_valid  = 1'b0;
        downloading = 1'b0;
        repeat (3) step();
        cfg_read(2'd2, st);
        check_equal("rom_ready status bit", st[1], 1'b1);
        check_equal("rom_ready", rom_ready, 1'b1);
    endtask

    task automatic raster_timing();
        int high_len;
        int period;
        measure_sync(2, high_len, period);
        check_equal("hs high clk", high_len, HS_LEN * CEN_DIV);
        check_equal("hs period clk", period, LINE_CLK);
        measure_sync(0, high_len, period);
        check_equal("lhbl high clk", high_len, H_ACTIVE * CEN_DIV);
        check_equal("lhbl period clk", period, LINE_CLK);
        measure_sync(3, high_len, period);
        check_equal("vs high clk", high_len, VS_LEN * LINE_CLK);
        check_equal("vs period clk", period, FRAME_CLK);
        measure_sync(1, high_len, period);
        check_equal("lvbl high clk", high_len, V_ACTIVE * LINE_CLK);
        check_equal("lvbl period clk", period, FRAME_CLK);
    endtask

    task automatic char_pixels();
        logic [7:0] base;
        for (int i = 0; i < 2; i++) begin
            base = 8'($urandom());
            cfg_write(2'd1, base);
            cfg_write(2'd0, 8'h01);
            wait_rise(1, "frame start");   // Flush fetches made with the old base
            if (aborted) return;
            check_frame(base, 1'b1);
            if (aborted) return;
        end
    endtask

    task automatic layer_disable();
        cfg_write(2'd0, 8'h00);
        check_frame(8'h00, 1'b0);
    endtask

    task automatic contended_host_reads();
        logic [7:0] st;
        rom_addr_t  a;
        cfg_write(2'd0, 8'h01);
        cfg_write(2'd2, 8'h00);
        for (int i = 0; i < 8; i++) begin
            a = rom_addr_t'($urandom());
            host_read(a);
            if (aborted) return;
            repeat (i * 5) step();
        end
        cfg_read(2'd2, st);
        check_equal("underrun status bit", st[0], 1'b0);
    endtask

    task automatic underrun_recovery();
        logic [7:0] st;
        int         n;
        ack_delay = 40;   // Longer than one tile
        n         = 0;
        st        = '0;
        while (!st[0]) begin
            step();
            cfg_read(2'd2, st);
            n++;
            if (n > 4000) begin
                ack_delay = 1;
                timed_out("underrun status bit");
                return;
            end
        end
        ack_delay = 1;
        repeat (2 * LINE_CLK) step();   // Let the fetcher recover
        cfg_write(2'd2, 8'h5a);
        cfg_read(2'd2, st);
        check_equal("underrun status bit", st[0], 1'b0);
        check_equal("rom_ready status bit", st[1], 1'b1);
    endtask

    initial begin
        void'($urandom(32'h5ab4));
        errors      = 0;
        timeouts    = 0;
        aborted     = 1'b0;
        ack_delay   = 1;
        arst_n      = 1'b0;
        downloading = 1'b1;   // Board comes up loading ROM
        host_req    = '0;
        host_valid  = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = 2'd0;
        cfg_wdata   = 8'd0;
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        download_gating();
        if (!aborted) raster_timing();
        if (!aborted) char_pixels();
        if (!aborted) layer_disable();
        if (!aborted) contended_host_reads();
        if (!aborted) underrun_recovery();

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/game_video_pkg.sv
logic/game_mem_pkg.sv
logic/game_timer.sv
logic/game_char_fetch.sv
logic/game_rom_arb.sv
logic/game_cfg_regs.sv
logic/game_top.sv
tb/game_tb.sv

// ==== Bender.yml ====
package:
  name: game_video

sources:
  - logic/game_video_pkg.sv
  - logic/game_mem_pkg.sv
  - logic/game_timer.sv
  - logic/game_char_fetch.sv
  - logic/game_rom_arb.sv
  - logic/game_cfg_regs.sv
  - logic/game_top.sv
  - target: simulation
    files:
      - tb/game_tb.sv
